// File: histPeak.f
logic/histPkg.sv
logic/histRam.sv
logic/histAccumulator.sv
logic/peakScanner.sv
logic/peakApbRegs.sv
logic/histTop.sv
verification/histTopTb.sv

// File: Bender.yml
package:
  name: histPeak

sources:
  - files:
      - logic/histPkg.sv
      - logic/histRam.sv
      - logic/histAccumulator.sv
      - logic/peakScanner.sv
      - logic/peakApbRegs.sv
      - logic/histTop.sv
  - target: test
    files:
      - verification/histTopTb.sv

// File: verification/histTopTb.sv
`timescale 1ns/1ps

module histTopTb import histPkg::*; ();

    localparam int clkPeriod = 40;
    localparam int resetCycles = 16;
    localparam int frameTotal = 3;
    localparam int samplesPerFrame = pixelNum * acqNum;
    // scanner time per frame is binNum reads plus two drain cycles per pixel
    localparam int scanCycles = pixelNum * (binNum + 2);
    localparam int pollCycles = 40;
    // worst case of 4 cycles per sample and then doubled
    localparam int timeoutLimit =
        2 * frameTotal * (samplesPerFrame * 4 + scanCycles + pollCycles);

    logic clk;
    logic rst;
    logic dataValid;
    timeStamp_t data;
    logic wrEn;
    apbReq_t apbIn;
    apbRsp_t apbOut;

    // stimulus by frame, round and pixel plus hand-worked peaks
    int stampTable [frameTotal][acqNum][pixelNum];
    int expBin [frameTotal][pixelNum];
    int expCount [frameTotal][pixelNum];

    int errorCount;
    int testCount;
    int testFails;
    int errorsAtStart;
    string testName;
    int held;
    int cycleCount;

    histTop uut (
        .clk       (clk),
        .rst       (rst),
        .dataValid (dataValid),
        .data      (data),
        .wrEn      (wrEn),
        .apbIn     (apbIn),
        .apbOut    (apbOut)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    // hard stop if the run hangs
    initial begin
        cycleCount = 0;
        while (cycleCount < timeoutLimit) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("timeout, run still going after %0d cycles", timeoutLimit);
        $display("*** FAILED ***");
        $finish;
    end

    task automatic setRound(input int f, input int r, input int s0, input int s1,
                            input int s2, input int s3);
        stampTable[f][r][0] = s0;
        stampTable[f][r][1] = s1;
        stampTable[f][r][2] = s2;
        stampTable[f][r][3] = s3;
    endtask

    // bin and count per pixel
    task automatic setPeaks(input int f, input int b0, input int c0, input int b1,
                            input int c1, input int b2, input int c2, input int b3,
                            input int c3);
        expBin[f] = '{b0, b1, b2, b3};
        expCount[f] = '{c0, c1, c2, c3};
    endtask

    task automatic loadTable();
        // frame 0 has one clear peak per pixel
        setRound(0, 0, 3, 10, 0, 12);
        setRound(0, 1, 1, 10, 15, 12);
        setRound(0, 2, 3, 10, 0, 2);
        setRound(0, 3, 7, 10, 5, 12);
        setRound(0, 4, 3, 10, 0, 12);
        setRound(0, 5, 9, 10, 15, 2);
        setRound(0, 6, 3, 10, 5, 12);
        setRound(0, 7, 3, 10, 0, 12);
        setPeaks(0, 3, 5, 10, 8, 0, 4, 12, 6);
        // frame 1 has ties where the lower bin must win
        setRound(1, 0, 6, 14, 8, 7);
        setRound(1, 1, 6, 2, 8, 6);
        setRound(1, 2, 11, 14, 1, 5);
        setRound(1, 3, 4, 2, 8, 4);
        setRound(1, 4, 6, 14, 8, 3);
        setRound(1, 5, 4, 2, 8, 2);
        setRound(1, 6, 11, 14, 8, 1);
        setRound(1, 7, 4, 2, 8, 0);
        setPeaks(1, 4, 3, 2, 4, 8, 7, 0, 1);
        // frame 2 avoids old peak bins so stale counts would win
        setRound(2, 0, 9, 5, 15, 9);
        setRound(2, 1, 13, 7, 14, 13);
        setRound(2, 2, 9, 5, 15, 9);
        setRound(2, 3, 1, 1, 14, 9);
        setRound(2, 4, 13, 5, 15, 13);
        setRound(2, 5, 7, 7, 14, 9);
        setRound(2, 6, 9, 1, 15, 13);
        setRound(2, 7, 15, 0, 14, 9);
        setPeaks(2, 9, 3, 5, 3, 14, 4, 9, 5);
    endtask

    task automatic startTest(input string name);
        testName = name;
        errorsAtStart = errorCount;
    endtask

    task automatic finishTest();
        testCount++;
        if (errorCount == errorsAtStart) begin
            $display("test %s: ok", testName);
        end else begin
            testFails++;
            $display("test %s: %0d errors", testName, errorCount - errorsAtStart);
        end
    endtask

    task automatic checkValue(input string name, input int got, input int exp);
        assert (got == exp) else begin
            $display("** Error at %0t ns: %s is %0d, expected %0d", $time, name, got, exp);
            errorCount++;
        end
    endtask

    // called on a falling edge and returns on the falling edge after acceptance
    task automatic driveSample(input int ts, input int idle, output int holdCount);
        holdCount = 0;
        dataValid = 1'b0;
        repeat (idle) @(negedge clk);
        dataValid = 1'b1;
        data = timeStamp_t'(ts);
        // wrEn only moves on rising edges so it is stable here
        while (!wrEn) begin
            holdCount++;
            @(negedge clk);
        end
        @(negedge clk);
        dataValid = 1'b0;
    endtask

    // sample i goes to pixel i mod pixelNum
    task automatic driveRange(input int f, input int first, input int last);
        int i;
        int holdCount;
        for (i = first; i <= last; i++) begin
            driveSample(stampTable[f][i / pixelNum][i % pixelNum], $urandom_range(3, 0),
                        holdCount);
        end
    endtask

    // setup then access phase with the response read in the low clock half
    task automatic apbAccess(input logic [apbAddrWidth-1:0] addr, input logic write,
                             input logic [apbDataWidth-1:0] wdata,
                             output logic [apbDataWidth-1:0] rdata, output logic err);
        apbIn.paddr = addr;
        apbIn.psel = 1'b1;
        apbIn.penable = 1'b0;
        apbIn.pwrite = write;
        apbIn.pwdata = wdata;
        @(negedge clk);
        apbIn.penable = 1'b1;
        #(clkPeriod / 4);
        rdata = apbOut.prdata;
        err = apbOut.pslverr;
        checkValue("pready", apbOut.pready, 1);
        @(negedge clk);
        apbIn.psel = 1'b0;
        apbIn.penable = 1'b0;
        apbIn.pwrite = 1'b0;
    endtask

    task automatic checkPeaks(input int f);
        int p;
        logic [apbDataWidth-1:0] rd;
        logic err;
        for (p = 0; p < pixelNum; p++) begin
            apbAccess(regPeakBase + apbAddrWidth'(4 * p), 1'b0, '0, rd, err);
            checkValue($sformatf("pslverr[%0d]", p), err, 0);
            checkValue($sformatf("peakBin[%0d]", p), rd[3:0], expBin[f][p]);
            checkValue($sformatf("peakCount[%0d]", p), rd[15:8], expCount[f][p]);
        end
    endtask

    // poll status until the frame count reaches target
    task automatic waitFrames(input int target);
        logic [apbDataWidth-1:0] rd;
        logic err;
        rd = '0;
        while (rd[15:0] < target) begin
            apbAccess(regStatusAddr, 1'b0, '0, rd, err);
        end
        checkValue("frameCount", rd[15:0], target);
        checkValue("busy", rd[16], 0);
        checkValue("pslverr", err, 0);
    endtask

    task automatic checkErrors(input int f);
        logic [apbDataWidth-1:0] rd;
        logic err;
        // writes are refused
        apbAccess(regPeakBase, 1'b1, 32'hffff_ffff, rd, err);
        checkValue("pslverr on peak write", err, 1);
        apbAccess(regStatusAddr, 1'b1, '0, rd, err);
        checkValue("pslverr on status write", err, 1);
        // reads past the map, misaligned and at the top of range
        apbAccess(regPeakBase + apbAddrWidth'(4 * pixelNum), 1'b0, '0, rd, err);
        checkValue("pslverr past map", err, 1);
        apbAccess(8'h06, 1'b0, '0, rd, err);
        checkValue("pslverr misaligned", err, 1);
        apbAccess(8'hfc, 1'b0, '0, rd, err);
        checkValue("pslverr at 0xfc", err, 1);
        // store untouched
        checkPeaks(f);
    endtask

    initial begin
        int f;
        void'($urandom(94));
        rst = 1'b1;
        dataValid = 1'b0;
        data = '0;
        apbIn = '0;
        errorCount = 0;
        testCount = 0;
        testFails = 0;
        loadTable();

        repeat (resetCycles) @(negedge clk);
        rst = 1'b0;
        // clearing pass holds wrEn low first
        while (!wrEn) @(negedge clk);

        driveRange(0, 0, samplesPerFrame - 1);
        for (f = 0; f < frameTotal; f++) begin
            if (f < frameTotal - 1) begin
                // first sample of the next frame offered right away and held
                startTest($sformatf("wrEn hold after frame %0d", f));
                driveSample(stampTable[f + 1][0][0], 0, held);
                assert (held >= scanCycles) else begin
                    $display("wrEn came back after %0d held cycles, scan needs %0d",
                             held, scanCycles);
                    errorCount++;
                end
                finishTest();
            end
            startTest($sformatf("frame %0d status", f));
            waitFrames(f + 1);
            finishTest();
            startTest($sformatf("frame %0d peaks", f));
            checkPeaks(f);
            finishTest();
            if (f == 0) begin
                startTest("apb error response");
                checkErrors(f);
                finishTest();
            end
            if (f < frameTotal - 1) begin
                driveRange(f + 1, 1, samplesPerFrame - 1);
            end
        end

        $display("summary: %0d tests, %0d failed, %0d check errors",
                 testCount, testFails, errorCount);
        if (errorCount == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: logic/histTop.sv
`timescale 1ns/1ps

module histTop import histPkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       dataValid,
    input  timeStamp_t data,
    output logic       wrEn,
    input  apbReq_t    apbIn,
    output apbRsp_t    apbOut
);

    // accumulator side of the memory
    logic accRdEn;
    binAddr_t accRaddr;
    ramWrite_t accWr;

    // scanner side of the memory
    logic scanRdEn;
    binAddr_t scanRaddr;
    ramWrite_t scanWr;

    // shared memory ports
    logic ramRdEn;
    binAddr_t ramRaddr;
    ramWrite_t ramWr;
    binCount_t ramRdata;

    logic busy;
    logic frameReady;
    peakResult_t result;
    logic resultValid;
    logic frameDone;

    // scanner owns both ports while busy
    assign ramRdEn = busy ? scanRdEn : accRdEn;
    assign ramRaddr = busy ? scanRaddr : accRaddr;
    assign ramWr = busy ? scanWr : accWr;

    histRam uRam (
        .clk   (clk),
        .wr    (ramWr),
        .rdEn  (ramRdEn),
        .raddr (ramRaddr),
        .rdata (ramRdata)
    );

    histAccumulator uAcc (
        .clk        (clk),
        .rst        (rst),
        .dataValid  (dataValid),
        .data       (data),
        .wrEn       (wrEn),
        .busy       (busy),
        .rdEn       (accRdEn),
        .raddr      (accRaddr),
        .rdata      (ramRdata),
        .wr         (accWr),
        .frameReady (frameReady)
    );

    peakScanner uScan (
        .clk         (clk),
        .rst         (rst),
        .frameReady  (frameReady),
        .busy        (busy),
        .rdEn        (scanRdEn),
        .raddr       (scanRaddr),
        .rdata       (ramRdata),
        .wr          (scanWr),
        .result      (result),
        .resultValid (resultValid),
        .frameDone   (frameDone)
    );

    peakApbRegs uRegs (
        .clk         (clk),
        .rst         (rst),
        .apbIn       (apbIn),
        .apbOut      (apbOut),
        .result      (result),
        .resultValid (resultValid),
        .frameDone   (frameDone),
        .busy        (busy)
    );

endmodule

// File: logic/peakApbRegs.sv
`timescale 1ns/1ps

module peakApbRegs import histPkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  apbReq_t     apbIn,
    output apbRsp_t     apbOut,
    input  peakResult_t result,
    input  logic        resultValid,
    input  logic        frameDone,
    input  logic        busy
);

    // per-pixel peak store
    timeStamp_t peakBin [pixelNum];
    binCount_t peakCount [pixelNum];

    frameCount_t frameCount;

    logic access;
    logic isStatus;
    logic isPeak;
    logic [apbAddrWidth-1:0] offset;
    pixelIdx_t peakSel;
    logic [apbDataWidth-1:0] readData;

    always_ff @(posedge clk) begin
        if (resultValid) begin
            peakBin[result.pixel] <= result.peakBin;
            peakCount[result.pixel] <= result.peakCount;
        end
    end

    // completed frames
    always_ff @(posedge clk) begin
        if (rst) begin
            frameCount <= '0;
        end else if (frameDone) begin
            frameCount <= frameCount + 1'b1;
        end
    end

    // address decode
    assign access = apbIn.psel && apbIn.penable;
    assign offset = apbIn.paddr - regPeakBase;
    // word index into the peak block
    assign peakSel = offset[pixelWidth+1:2];
    assign isStatus = (apbIn.paddr == regStatusAddr);
    assign isPeak = (apbIn.paddr >= regPeakBase)
                 && (offset < apbAddrWidth'(4 * pixelNum))
                 && (offset[1:0] == 2'b00);

    // read mux
    always_comb begin
        readData = '0;
        if (isStatus) begin
            readData[frameWidth-1:0] = frameCount;
            readData[frameWidth] = busy;
        end else if (isPeak) begin
            // bin in the low nibble, count in the second byte
            readData[tsWidth-1:0] = peakBin[peakSel];
            readData[8 +: countWidth] = peakCount[peakSel];
        end
    end

    // zero wait states, read-only map
    always_comb begin
        apbOut.prdata = readData;
        apbOut.pready = 1'b1;
        apbOut.pslverr = access && (apbIn.pwrite || !(isStatus || isPeak));
    end

endmodule

// File: logic/peakScanner.sv
`timescale 1ns/1ps

module peakScanner import histPkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        frameReady,
    output logic        busy,
    output logic        rdEn,
    output binAddr_t    raddr,
    input  binCount_t   rdata,
    output ramWrite_t   wr,
    output peakResult_t result,
    output logic        resultValid,
    output logic        frameDone
);

    typedef enum logic [1:0] {
        stIdle,
        stScan,
        stDrain
    } scanState_t;

    scanState_t state;

    // set by reset, one silent pass that zeroes the memory
    logic clearPass;

    pixelIdx_t pixel;
    timeStamp_t bin;
    // second drain cycle
    logic drainLast;

    // read issued last cycle, its data is on rdata now
    logic cmpValid;
    binAddr_t cmpAddr;
    timeStamp_t cmpBin;

    // running maximum of the current pixel
    timeStamp_t maxBin;
    binCount_t maxCount;

    logic lastPixel;
    logic lastBin;

    assign lastPixel = (pixel == pixelIdx_t'(pixelNum - 1));
    assign lastBin = (bin == timeStamp_t'(binNum - 1));
    assign cmpBin = cmpAddr[tsWidth-1:0];

    assign busy = (state != stIdle) || clearPass;

    // one bin per scan cycle
    assign rdEn = (state == stScan);
    assign raddr = {pixel, bin};

    // zero written behind each read
    always_comb begin
        wr.addr = cmpAddr;
        wr.data = '0;
        wr.en = cmpValid;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= stIdle;
            clearPass <= 1'b1;
            pixel <= '0;
            bin <= '0;
            drainLast <= 1'b0;
            cmpValid <= 1'b0;
            resultValid <= 1'b0;
            frameDone <= 1'b0;
        end else begin
            resultValid <= 1'b0;
            frameDone <= 1'b0;
            cmpValid <= (state == stScan);
            case (state)
                stIdle: begin
                    if (frameReady || clearPass) begin
                        pixel <= '0;
                        bin <= '0;
                        state <= stScan;
                    end
                end
                stScan: begin
                    bin <= bin + 1'b1;
                    if (lastBin) begin
                        drainLast <= 1'b0;
                        state <= stDrain;
                    end
                end
                stDrain: begin
                    drainLast <= 1'b1;
                    // last compare landed on the previous edge
                    if (drainLast) begin
                        resultValid <= !clearPass;
                        bin <= '0;
                        if (lastPixel) begin
                            frameDone <= !clearPass;
                            clearPass <= 1'b0;
                            state <= stIdle;
                        end else begin
                            pixel <= pixel + 1'b1;
                            state <= stScan;
                        end
                    end
                end
                default: begin
                    state <= stIdle;
                end
            endcase
        end
    end

    // bin 0 restarts the maximum, strictly greater keeps the lowest bin on a tie
    always_ff @(posedge clk) begin
        cmpAddr <= {pixel, bin};
        if (cmpValid && ((cmpBin == '0) || (rdata > maxCount))) begin
            maxCount <= rdata;
            maxBin <= cmpBin;
        end
        if ((state == stDrain) && drainLast) begin
            result.pixel <= pixel;
            result.peakBin <= maxBin;
            result.peakCount <= maxCount;
        end
    end

endmodule

// File: logic/histAccumulator.sv
`timescale 1ns/1ps

module histAccumulator import histPkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       dataValid,
    input  timeStamp_t data,
    output logic       wrEn,
    input  logic       busy,
    output logic       rdEn,
    output binAddr_t   raddr,
    input  binCount_t  rdata,
    output ramWrite_t  wr,
    output logic       frameReady
);

    typedef enum logic [1:0] {
        stAccept,
        stDrain,
        stWaitScan
    } accState_t;

    accState_t state;

    // position of the next sample within the frame
    pixelIdx_t pixel;
    logic [roundWidth-1:0] round;

    logic accept;
    logic lastPixel;
    logic lastSample;

    // stage 1 holds the read, stage 2 the write back
    logic s1Valid;
    binAddr_t s1Addr;
    logic s2Valid;
    binAddr_t s2Addr;

    // source is held while draining, waiting, or while the scanner owns the memory
    assign wrEn = (state == stAccept) && !busy;
    assign accept = dataValid && wrEn;

    assign lastPixel = (pixel == pixelIdx_t'(pixelNum - 1));
    // last pixel of the last round closes the frame
    assign lastSample = lastPixel && (round == roundWidth'(acqNum - 1));

    // frame bookkeeping
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= stAccept;
            pixel <= '0;
            round <= '0;
            frameReady <= 1'b0;
        end else begin
            frameReady <= 1'b0;
            case (state)
                stAccept: begin
                    if (accept) begin
                        if (lastPixel) begin
                            pixel <= '0;
                            if (lastSample) begin
                                round <= '0;
                                // wrEn drops on this edge
                                state <= stDrain;
                            end else begin
                                round <= round + 1'b1;
                            end
                        end else begin
                            pixel <= pixel + 1'b1;
                        end
                    end
                end
                stDrain: begin
                    // stage 1 empty, last write lands on this edge
                    if (!s1Valid) begin
                        frameReady <= 1'b1;
                        state <= stWaitScan;
                    end
                end
                stWaitScan: begin
                    // busy only rises one cycle after the frameReady pulse
                    if (!busy && !frameReady) begin
                        state <= stAccept;
                    end
                end
                default: begin
                    state <= stAccept;
                end
            endcase
        end
    end

    // pipeline valids
    always_ff @(posedge clk) begin
        if (rst) begin
            s1Valid <= 1'b0;
            s2Valid <= 1'b0;
        end else begin
            s1Valid <= accept;
            s2Valid <= s1Valid;
        end
    end

    // address travels alongside the read
    always_ff @(posedge clk) begin
        if (accept) begin
            s1Addr <= {pixel, data};
        end
        s2Addr <= s1Addr;
    end

    // bin read in the cycle after acceptance
    assign rdEn = s1Valid;
    assign raddr = s1Addr;

    // incremented count written one cycle after the read
    // no overflow, a frame adds at most acqNum to a bin
    always_comb begin
        wr.addr = s2Addr;
        wr.data = rdata + binCount_t'(1);
        wr.en = s2Valid;
    end

endmodule

// File: logic/histRam.sv
`timescale 1ns/1ps

module histRam import histPkg::*; (
    input  logic      clk,
    input  ramWrite_t wr,
    input  logic      rdEn,
    input  binAddr_t  raddr,
    output binCount_t rdata
);

    // one count per bin of every pixel
    localparam int depth = binNum * pixelNum;

    binCount_t mem [depth];

    // write port
    // accumulator and scanner never aim read and write at one bin in one cycle
    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.data;
        end
    end

    // read port, data one cycle after the address
    // holds its last value while rdEn is low
    always_ff @(posedge clk) begin
        if (rdEn) begin
            rdata <= mem[raddr];
        end
    end

endmodule

// File: logic/histPkg.sv
package histPkg;

    // frame geometry
    localparam int pixelNum = 4;
    localparam int acqNum = 8;
    localparam int tsWidth = 4;
    // one bin per time-stamp code
    localparam int binNum = 1 << tsWidth;
    localparam int countWidth = 8;

    // derived index widths
    localparam int pixelWidth = $clog2(pixelNum);
    localparam int roundWidth = $clog2(acqNum);
    // pixel sits above bin in the memory address
    localparam int addrWidth = pixelWidth + tsWidth;
    localparam int frameWidth = 16;

    // host bus
    localparam int apbAddrWidth = 8;
    localparam int apbDataWidth = 32;

    // byte address map, peak p at regPeakBase + 4*p
    localparam logic [apbAddrWidth-1:0] regStatusAddr = 8'h00;
    localparam logic [apbAddrWidth-1:0] regPeakBase = 8'h04;

    typedef logic [tsWidth-1:0] timeStamp_t;
    typedef logic [countWidth-1:0] binCount_t;
    typedef logic [pixelWidth-1:0] pixelIdx_t;
    typedef logic [addrWidth-1:0] binAddr_t;
    typedef logic [frameWidth-1:0] frameCount_t;

    // one write request into the bin memory
    typedef struct packed {
        binAddr_t addr;
        binCount_t data;
        logic en;
    } ramWrite_t;

    // one scanner result per pixel
    typedef struct packed {
        pixelIdx_t pixel;
        timeStamp_t peakBin;
        binCount_t peakCount;
    } peakResult_t;

    typedef struct packed {
        logic [apbAddrWidth-1:0] paddr;
        logic psel;
        logic penable;
        logic pwrite;
        logic [apbDataWidth-1:0] pwdata;
    } apbReq_t;

    typedef struct packed {
        logic [apbDataWidth-1:0] prdata;
        logic pready;
        logic pslverr;
    } apbRsp_t;

endpackage
